/* car_game_pkg.sv */
//------------------------------------------------
// Shared constants and types of the lane game
// Rows are 8 bits wide, bit 7 is the leftmost LED
// Row 0 is the top of the matrix, row 7 the player
//------------------------------------------------
package car_game_pkg;

	//------------------------------------------------
	// Timing constants
	//------------------------------------------------
	// Stable samples before a button level is accepted
	localparam int DEBOUNCE_CYCLES = 8;
	// Road tick period in level 0, in clocks
	localparam int TICK_BASE = 64;
	// Period cut per level
	localparam int TICK_STEP = 8;
	// Ticks per level
	localparam int LEVEL_LENGTH = 8;
	// Finishing the last level wins
	localparam int NUM_LEVELS = 4;
	// Lane after a start press
	localparam int PLAYER_START_LANE = 5;

	//------------------------------------------------
	// Vector types
	//------------------------------------------------
	typedef logic [7:0] row_t;
	typedef logic [2:0] lane_t;
	typedef logic [1:0] level_t;
	typedef logic [2:0] progress_t;
	typedef logic [6:0] tick_count_t;

	// Top level game FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} game_state_t;

	// One-cycle press pulses, one per button
	typedef struct packed {
		logic start;
		logic left;
		logic right;
	} presses_t;

	// Game progress as seen by the road and player stages
	typedef struct packed {
		game_state_t state;
		logic        tick;
		level_t      level;
		progress_t   progress;
	} game_status_t;

	//------------------------------------------------
	// Fixed pictures
	//------------------------------------------------
	// Idle arrow, row 0 first
	localparam row_t START_FRAME [8] = '{
		8'b00010000,
		8'b00000000,
		8'b00010000,
		8'b00111000,
		8'b01111100,
		8'b01111100,
		8'b00111000,
		8'b00010000
	};

	// Game over bar, same on every row
	localparam row_t OVER_ROW = 8'b00011000;

endpackage

/* button_debounce.sv */
//------------------------------------------------
// One active-low push button, no pull-up handling
// Pin fall to press pulse is DEBOUNCE_CYCLES+2 clocks
//------------------------------------------------
`timescale 1ns/1ps

module button_debounce
	import car_game_pkg::*;
(
	input  logic clock_50,
	input  logic rst_n,
	input  logic button_n,
	output logic pressed
);

	// Two flop synchroniser, idles high like the pin
	logic [1:0] sync_q;
	// Accepted level, high while pressed
	logic level_q;
	// Consecutive samples that differ from level_q
	logic [$clog2(DEBOUNCE_CYCLES)-1:0] stable_cnt;
	logic sample;

	// Active high view of the synchronised pin
	assign sample = ~sync_q[1];

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			sync_q     <= 2'b11;
			level_q    <= 1'b0;
			stable_cnt <= '0;
			pressed    <= 1'b0;
		end else begin
			sync_q  <= {sync_q[0], button_n};
			pressed <= 1'b0;
			if (sample == level_q) begin
				// Bounce or no change, start over
				stable_cnt <= '0;
			end else if (int'(stable_cnt) == DEBOUNCE_CYCLES - 1) begin
				// Enough stable samples, take the new level
				stable_cnt <= '0;
				level_q    <= sample;
				// Pulse only on the pressed edge
				pressed    <= sample;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// A press is a single cycle event
	assert property (@(posedge clock_50) disable iff (!rst_n)
		pressed |=> !pressed);

endmodule

/* game_control.sv */
//------------------------------------------------
// Game FSM with level dependent road prescaler
// Start is ignored while a game is running
// Level counter wraps to 0 when the game is won
//------------------------------------------------
`timescale 1ns/1ps

module game_control
	import car_game_pkg::*;
(
	input  logic         clock_50,
	input  logic         rst_n,
	input  logic         start,
	input  logic         collision,
	output game_status_t status
);

	game_state_t state_q;
	tick_count_t tick_cnt_q;
	tick_count_t tick_limit;
	level_t      level_q;
	progress_t   progress_q;
	logic        tick;
	logic        level_done;
	logic        game_done;

	//------------------------------------------------
	// Road prescaler
	//------------------------------------------------
	// Last count of the period drops by TICK_STEP per level
	assign tick_limit = tick_count_t'(TICK_BASE - 1 - TICK_STEP * int'(level_q));

	// Ticks exist only while playing
	assign tick = (state_q == ST_PLAY) && (tick_cnt_q == tick_limit);

	// Last tick of a level
	assign level_done = tick && (int'(progress_q) == LEVEL_LENGTH - 1);
	// Last tick of the last level
	assign game_done = level_done && (int'(level_q) == NUM_LEVELS - 1);

	//------------------------------------------------
	// State and counters
	//------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state_q    <= ST_IDLE;
			tick_cnt_q <= '0;
			progress_q <= '0;
			level_q    <= '0;
		end else begin
			case (state_q)
				ST_IDLE, ST_OVER: begin
					// New game from a clean count
					if (start) begin
						state_q    <= ST_PLAY;
						tick_cnt_q <= '0;
						progress_q <= '0;
						level_q    <= '0;
					end
				end
				ST_PLAY: begin
					// Free running count that restarts after each tick
					if (tick) begin
						tick_cnt_q <= '0;
					end else begin
						tick_cnt_q <= tick_cnt_q + 1'b1;
					end
					// Progress within the level
					if (level_done) begin
						progress_q <= '0;
						level_q    <= level_q + 1'b1;
					end else if (tick) begin
						progress_q <= progress_q + 1'b1;
					end
					// Crash or finish both end the game
					if (collision || game_done) begin
						state_q <= ST_OVER;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Status bundle for the road and player stages
	always_comb begin
		status.state    = state_q;
		status.tick     = tick;
		status.level    = level_q;
		status.progress = progress_q;
	end

	// Count in play never passes the last count of the period
	assert property (@(posedge clock_50) disable iff (!rst_n)
		(state_q == ST_PLAY) |-> (tick_cnt_q <= tick_limit));

endmodule

/* road_scroller.sv */
//------------------------------------------------
// Eight row road entering at row 0 on top
// Shifts once per tick and clears on any start press
//------------------------------------------------
`timescale 1ns/1ps

module road_scroller
	import car_game_pkg::*;
(
	input  logic         clock_50,
	input  logic         rst_n,
	input  logic         start,
	input  game_status_t status,
	output row_t         road [8]
);

	lane_t car_lane;
	row_t  new_row;

	//------------------------------------------------
	// Car pattern
	//------------------------------------------------
	// Lane from the pre-tick counts truncated to mod 8
	assign car_lane = lane_t'(3 * int'(status.progress) + 5 * int'(status.level));

	// Even progress gets a car and odd progress a gap
	assign new_row = status.progress[0] ? '0 : row_t'(8'b1 << car_lane);

	//------------------------------------------------
	// Road shift register
	//------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (!rst_n || start) begin
			// Empty road for a new game
			for (int i = 0; i < 8; i++) begin
				road[i] <= '0;
			end
		end else if (status.tick) begin
			road[0] <= new_row;
			// Every row moves one step down
			for (int i = 1; i < 8; i++) begin
				road[i] <= road[i-1];
			end
		end
	end

	// New top row holds one car at most and never sits right above another
	assert property (@(posedge clock_50) disable iff (!rst_n)
		status.tick && !start |=> $onehot0(road[0]) && !((|road[0]) && (|road[1])));

endmodule

/* player_position.sv */
//------------------------------------------------
// Player lane in the bottom row
// Left raises the lane, right lowers it, both do nothing
//------------------------------------------------
`timescale 1ns/1ps

module player_position
	import car_game_pkg::*;
(
	input  logic        clock_50,
	input  logic        rst_n,
	input  presses_t    presses,
	input  game_state_t state,
	output row_t        player_row
);

	lane_t lane_q;

	always_ff @(posedge clock_50) begin
		if (!rst_n || presses.start) begin
			lane_q <= lane_t'(PLAYER_START_LANE);
		end else if (state == ST_PLAY) begin
			// Saturate at the matrix edges
			if (presses.left && !presses.right && lane_q != '1) begin
				lane_q <= lane_q + 1'b1;
			end else if (presses.right && !presses.left && lane_q != '0) begin
				lane_q <= lane_q - 1'b1;
			end
		end
	end

	// One LED for the car
	assign player_row = row_t'(8'b1 << lane_q);

	// Always one car, and it moves by one lane at most per cycle
	assert property (@(posedge clock_50) disable iff (!rst_n)
		!presses.start |=> $onehot(player_row) &&
			(player_row == $past(player_row) ||
			 player_row == row_t'($past(player_row) << 1) ||
			 player_row == row_t'($past(player_row) >> 1)));

endmodule

/* frame_composer.sv */
//------------------------------------------------
// Registered 8x8 frame and column scan readout
// disp_data is combinational from disp_addr
//------------------------------------------------
`timescale 1ns/1ps

module frame_composer
	import car_game_pkg::*;
(
	input  logic        clock_50,
	input  logic        rst_n,
	input  game_state_t state,
	input  row_t        road [8],
	input  row_t        player_row,
	input  lane_t       disp_addr,
	output logic        collision,
	output row_t        disp_data
);

	row_t frame_q [8];

	// Car in the bottom row on the player's lane
	assign collision = (state == ST_PLAY) && (|(road[7] & player_row));

	//------------------------------------------------
	// Frame select by game state
	//------------------------------------------------
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			frame_q <= START_FRAME;
		end else begin
			case (state)
				ST_PLAY: begin
					for (int i = 0; i < 7; i++) begin
						frame_q[i] <= road[i];
					end
					// Player drawn over the bottom road row
					frame_q[7] <= road[7] | player_row;
				end
				ST_OVER: begin
					for (int i = 0; i < 8; i++) begin
						frame_q[i] <= OVER_ROW;
					end
				end
				default: begin
					frame_q <= START_FRAME;
				end
			endcase
		end
	end

	//------------------------------------------------
	// Column readout
	//------------------------------------------------
	// Address 0 is the leftmost column, row 0 lands in bit 7
	always_comb begin
		for (int r = 0; r < 8; r++) begin
			disp_data[7-r] = frame_q[r][~disp_addr];
		end
	end

endmodule

/* car_game_top.sv */
//------------------------------------------------
// Lane game top, one player, column scan output
// Buttons are raw active-low pins
//------------------------------------------------
`timescale 1ns/1ps

module car_game_top
	import car_game_pkg::*;
(
	input  logic  clock_50,
	input  logic  rst_n,
	input  logic  start_button_n,
	input  logic  left_button_n,
	input  logic  right_button_n,
	input  lane_t disp_addr,
	output row_t  disp_data
);

	presses_t     presses;
	game_status_t status;
	row_t         road [8];
	row_t         player_row;
	logic         collision;

	//------------------------------------------------
	// Buttons
	//------------------------------------------------
	button_debounce u_start_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (start_button_n),
		.pressed  (presses.start)
	);

	button_debounce u_left_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (left_button_n),
		.pressed  (presses.left)
	);

	button_debounce u_right_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (right_button_n),
		.pressed  (presses.right)
	);

	//------------------------------------------------
	// Game flow
	//------------------------------------------------
	game_control u_game_control (
		.clock_50  (clock_50),
		.rst_n     (rst_n),
		.start     (presses.start),
		.collision (collision),
		.status    (status)
	);

	road_scroller u_road_scroller (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.start    (presses.start),
		.status   (status),
		.road     (road)
	);

	player_position u_player_position (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.presses    (presses),
		.state      (status.state),
		.player_row (player_row)
	);

	// Frame build and display scan
	frame_composer u_frame_composer (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.state      (status.state),
		.road       (road),
		.player_row (player_row),
		.disp_addr  (disp_addr),
		.collision  (collision),
		.disp_data  (disp_data)
	);

endmodule

/* tb_car_game.sv */
//------------------------------------------------
// Lane game testbench, one column compared per cycle
// Start is pressed only while no game is running
// Even games are steered, odd games take random moves
//------------------------------------------------
`timescale 1ns/1ps

module tb_car_game
	import car_game_pkg::*;
();

	localparam int HOLD_CYCLES = 3 * DEBOUNCE_CYCLES;
	localparam int WATCHDOG_CYCLES = 10 * (NUM_LEVELS * LEVEL_LENGTH * TICK_BASE + 2000);
	localparam presses_t NO_PRESS = 3'b000;
	localparam presses_t START_PRESS = 3'b100;
	localparam presses_t LEFT_PRESS = 3'b010;
	localparam presses_t RIGHT_PRESS = 3'b001;

	logic  clock_50;
	logic  rst_n;
	logic  start_button_n;
	logic  left_button_n;
	logic  right_button_n;
	lane_t disp_addr;
	row_t  disp_data;

	logic [31:0] lfsr;
	int          n_checks;
	int          n_errors;

	//------------------------------------------------
	// Model state, stepped once per rising edge
	//------------------------------------------------
	game_state_t m_state;
	int          m_cnt;
	int          m_level;
	int          m_prog;
	int          m_lane;
	row_t        m_road [8];
	row_t        m_frame [8];
	presses_t    m_press;
	// Consecutive edges that saw each pin low
	int          m_low [3];
	logic        m_crashed;

	car_game_top i_car_game_top (
		.clock_50       (clock_50),
		.rst_n          (rst_n),
		.start_button_n (start_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.disp_addr      (disp_addr),
		.disp_data      (disp_data)
	);

	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_50);
		$display("timeout: the games did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	// Galois LFSR, one step per bit taken
	function automatic int rand_bits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("mismatch at time %0t: %s is %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	task automatic model_reset();
		m_state = ST_IDLE;
		m_cnt = 0;
		m_level = 0;
		m_prog = 0;
		m_lane = PLAYER_START_LANE;
		m_press = NO_PRESS;
		for (int r = 0; r < 8; r++) begin
			m_road[r] = '0;
			m_frame[r] = START_FRAME[r];
		end
		for (int b = 0; b < 3; b++) begin
			m_low[b] = 0;
		end
	endtask

	// One clock edge of the game rules, all from pre-edge values
	task automatic model_edge();
		logic       tick;
		logic       coll;
		logic [2:0] pins;
		logic [2:0] press_v;
		row_t       player;
		pins = {~start_button_n, ~left_button_n, ~right_button_n};
		player = row_t'(1 << m_lane);
		tick = (m_state == ST_PLAY) && (m_cnt == TICK_BASE - TICK_STEP * m_level - 1);
		coll = (m_state == ST_PLAY) && ((m_road[7] & player) != '0);
		if (!rst_n) begin
			model_reset();
		end else begin
			// Frame picture of the current state
			for (int r = 0; r < 8; r++) begin
				case (m_state)
					ST_PLAY: m_frame[r] = (r == 7) ? (m_road[7] | player) : m_road[r];
					ST_OVER: m_frame[r] = OVER_ROW;
					default: m_frame[r] = START_FRAME[r];
				endcase
			end
			// Road, new car on even progress only
			if (m_press.start) begin
				for (int r = 0; r < 8; r++) begin
					m_road[r] = '0;
				end
			end else if (tick) begin
				for (int r = 7; r > 0; r--) begin
					m_road[r] = m_road[r-1];
				end
				m_road[0] = (m_prog % 2 == 1) ? '0 :
					row_t'(1 << ((3 * m_prog + 5 * m_level) % 8));
			end
			// Player lane, left is up
			if (m_press.start) begin
				m_lane = PLAYER_START_LANE;
			end else if (m_state == ST_PLAY && m_press.left != m_press.right) begin
				if (m_press.left && m_lane < 7) m_lane++;
				if (m_press.right && m_lane > 0) m_lane--;
			end
			// Game FSM and counters
			if (m_state != ST_PLAY) begin
				if (m_press.start) begin
					m_state = ST_PLAY;
					m_cnt = 0;
					m_prog = 0;
					m_level = 0;
					m_crashed = 1'b0;
				end
			end else begin
				m_cnt = tick ? 0 : m_cnt + 1;
				if (tick) begin
					m_prog = (m_prog + 1) % LEVEL_LENGTH;
					if (m_prog == 0) begin
						if (m_level == NUM_LEVELS - 1) m_state = ST_OVER;
						m_level = (m_level + 1) % NUM_LEVELS;
					end
				end
				if (coll) begin
					m_state = ST_OVER;
					m_crashed = 1'b1;
				end
			end
			// Pulse on the edge that saw the pin low for the Nth time
			for (int b = 0; b < 3; b++) begin
				m_low[b] = pins[b] ? m_low[b] + 1 : 0;
				press_v[b] = (m_low[b] == DEBOUNCE_CYCLES + 2);
			end
			m_press = presses_t'(press_v);
		end
	endtask

	function automatic row_t model_column(input lane_t addr);
		row_t col;
		for (int r = 0; r < 8; r++) begin
			col[7-r] = m_frame[r][7 - int'(addr)];
		end
		return col;
	endfunction

	//------------------------------------------------
	// Cycle driver
	//------------------------------------------------
	task automatic step_cycle(input presses_t hold, input logic rst_val = 1'b1);
		@(posedge clock_50);
		model_edge();
		#1;
		rst_n = rst_val;
		start_button_n = ~hold.start;
		left_button_n = ~hold.left;
		right_button_n = ~hold.right;
		disp_addr = lane_t'(rand_bits(3));
		#2;
		check_value(32'(disp_data), 32'(model_column(disp_addr)), "disp_data column");
	endtask

	task automatic apply_reset();
		repeat (16) step_cycle(NO_PRESS, 1'b0);
		step_cycle(NO_PRESS);
	endtask

	task automatic press_buttons(input presses_t which);
		repeat (HOLD_CYCLES) step_cycle(which);
		repeat (HOLD_CYCLES) step_cycle(NO_PRESS);
	endtask

	// Step aside when the next car to reach row 7 is in our lane
	function automatic presses_t dodge_move();
		for (int r = 6; r >= 0; r--) begin
			if (m_road[r] != '0) begin
				if (m_road[r][m_lane]) return (m_lane < 7) ? LEFT_PRESS : RIGHT_PRESS;
				return NO_PRESS;
			end
		end
		return NO_PRESS;
	endfunction

	task automatic play_game(input int game, input logic steered);
		presses_t move;
		press_buttons(START_PRESS);
		while (m_state == ST_PLAY) begin
			if (steered) begin
				move = dodge_move();
			end else begin
				// Both buttons together in one case of four
				move = presses_t'(rand_bits(2));
			end
			if (move != NO_PRESS) begin
				press_buttons(move);
			end else begin
				repeat (steered ? 1 : rand_bits(4) + 1) step_cycle(NO_PRESS);
			end
		end
		// Let the over picture settle and get scanned
		repeat (HOLD_CYCLES) step_cycle(NO_PRESS);
		$display("game %0d over, steered %0b, collision %0b", game, steered, m_crashed);
		if (steered) begin
			check_value(32'(m_crashed), 32'(0), "collision in steered game");
		end
	endtask

	initial begin
		lfsr = 32'h52fd;
		n_checks = 0;
		n_errors = 0;
		rst_n = 1'b0;
		start_button_n = 1'b1;
		left_button_n = 1'b1;
		right_button_n = 1'b1;
		disp_addr = '0;
		m_crashed = 1'b0;
		model_reset();
		apply_reset();
		for (int g = 0; g < 10; g++) begin
			// Back to idle halfway through
			if (g == 5) apply_reset();
			play_game(g, (g % 2) == 0);
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* build.f */
car_game_pkg.sv
button_debounce.sv
game_control.sv
road_scroller.sv
player_position.sv
frame_composer.sv
car_game_top.sv
tb_car_game.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_car_game
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless the run passes"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
